/* list.f */
+incdir+src
src/fe_pkg.sv
src/branch_predictor.sv
src/fetch_unit.sv
src/inflight_queue.sv
src/branch_resolver.sv
src/rv_frontend.sv
sim/tb_rv_frontend.sv

/* run_sim.sh */
#!/bin/sh
# build and run the front end testbench with verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_rv_frontend
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --top-module "$TOP" -Mdir "$BUILD_DIR" -f list.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi

if grep -q "Result: FAILED" "$LOG"; then
  exit 1
fi
exit 0

/* sim/tb_rv_frontend.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fe_macros.svh"

module tb_rv_frontend;
  import fe_pkg::*;

  localparam int N_ROWS     = 15;
  localparam int N_PROG     = 9;
  localparam int LONG_DELAY = 20;                  // slow enough to fill the queue
  localparam int TIMEOUT    = 40 * N_ROWS + 200;   // cycles

  typedef struct packed {
    addr_t  adr;
    instr_t word;
  } prog_row_t;

  typedef struct packed {
    addr_t      pc;       // expected issue pc
    addr_t      next_pc;  // actual next pc from execute
    logic [7:0] delay;    // cycles before resolve
    logic       miss;     // expected mispredict
  } trace_row_t;

  logic       clk = 1'b0;
  logic       rstn;
  logic       wb_cyc;
  logic       wb_stb;
  addr_t      wb_adr;
  logic       wb_ack = 1'b0;
  instr_t     wb_dat_i = '0;
  fetch_rec_t issue;
  logic       issue_valid;
  logic       resolve_valid;
  addr_t      resolve_next_pc;
  logic       mispredict;
  perf_t      perf;

  prog_row_t  program_tbl [N_PROG];
  trace_row_t trace [N_ROWS];
  instr_t     prog_mem [64];  // first 256 bytes

  int    seed = 88158;
  int    errors = 0;
  int    bus_faults = 0;  // owned by the memory model
  int    cycle_count = 0;
  int    ack_count = 0;   // acks seen by the dut
  int    exp_branches = 0;
  int    exp_jumps = 0;
  int    exp_correct = 0;
  int    exp_miss = 0;
  logic  mem_busy = 1'b0;
  addr_t mem_adr = '0;
  int    wait_left = 0;

  rv_frontend rv_frontend_inst (
    .clk             (clk),
    .rstn            (rstn),
    .wb_cyc          (wb_cyc),
    .wb_stb          (wb_stb),
    .wb_adr          (wb_adr),
    .wb_ack          (wb_ack),
    .wb_dat_i        (wb_dat_i),
    .issue           (issue),
    .issue_valid     (issue_valid),
    .resolve_valid   (resolve_valid),
    .resolve_next_pc (resolve_next_pc),
    .mispredict      (mispredict),
    .perf            (perf)
  );

  always #5 clk = ~clk;  // 10 ns period

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp,
                          input string what, inout int fails);
    if (got !== exp) begin
      fails = fails + 1;
      $display("FAIL @ %0t: %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // op-imm opcode so unlisted words decode as other
  function automatic instr_t fill_word(input addr_t a);
    return {a[31:7] ^ a[24:0], 7'b0010011};
  endfunction

  function automatic instr_t read_word(input addr_t a);
    instr_t w;
    if (a[31:8] == 24'd0) w = prog_mem[a[7:2]];
    else                  w = fill_word(a);
    return w;
  endfunction

  // rv32i opcode classes
  function automatic instr_kind_e kind_of(input instr_t w);
    instr_kind_e k;
    case (w[6:0])
      `FE_OP_BRANCH: k = KIND_BRANCH;
      `FE_OP_JAL:    k = KIND_JAL;
      `FE_OP_JALR:   k = KIND_JALR;
      default:       k = KIND_OTHER;
    endcase
    return k;
  endfunction

  task automatic load_tables();
    program_tbl[0] = '{32'h0000_0000, 32'h0000_0013};  // nop
    program_tbl[1] = '{32'h0000_0004, 32'hfff0_8093};  // addi x1,x1,-1
    program_tbl[2] = '{32'h0000_0008, 32'hfe00_9ee3};  // bne x1,x0,-4  loop back
    program_tbl[3] = '{32'h0000_000c, 32'h0140_006f};  // jal x0,+20
    program_tbl[4] = '{32'h0000_0020, 32'h0000_0013};
    program_tbl[5] = '{32'h0000_0024, 32'h0000_8463};  // beq x1,x0,+8  falls through
    program_tbl[6] = '{32'h0000_0028, 32'h0002_8067};  // jalr x0,0(x5)
    program_tbl[7] = '{32'h0000_0040, 32'h0000_0013};
    program_tbl[8] = '{32'h0000_0044, 32'h0000_0013};
    for (int i = 0; i < 64; i++) prog_mem[i] = fill_word(addr_t'(i) << 2);
    for (int i = 0; i < N_PROG; i++) prog_mem[program_tbl[i].adr[7:2]] = program_tbl[i].word;
    // loop taken 3 times with a miss on the first pass and on the exit
    trace[0]  = '{32'h0000_0000, 32'h0000_0004, 8'd1,  1'b0};
    trace[1]  = '{32'h0000_0004, 32'h0000_0008, 8'd0,  1'b0};
    trace[2]  = '{32'h0000_0008, 32'h0000_0004, 8'd2,  1'b1};  // btb empty
    trace[3]  = '{32'h0000_0004, 32'h0000_0008, 8'd0,  1'b0};
    trace[4]  = '{32'h0000_0008, 32'h0000_0004, 8'd1,  1'b0};  // weakly taken hit
    trace[5]  = '{32'h0000_0004, 32'h0000_0008, 8'd3,  1'b0};
    trace[6]  = '{32'h0000_0008, 32'h0000_0004, 8'd0,  1'b0};
    trace[7]  = '{32'h0000_0004, 32'h0000_0008, 8'd2,  1'b0};
    trace[8]  = '{32'h0000_0008, 32'h0000_000c, 8'd1,  1'b1};  // loop exit
    trace[9]  = '{32'h0000_000c, 32'h0000_0020, 8'd0,  1'b1};  // jal not in btb
    trace[10] = '{32'h0000_0020, 32'h0000_0024, 8'd2,  1'b0};
    trace[11] = '{32'h0000_0024, 32'h0000_0028, 8'd1,  1'b0};  // miss means pc+4
    trace[12] = '{32'h0000_0028, 32'h0000_0040, 8'd0,  1'b1};  // jalr not in btb
    trace[13] = '{32'h0000_0040, 32'h0000_0044, 8'd30, 1'b0};  // back-pressure
    trace[14] = '{32'h0000_0044, 32'h0000_0048, 8'd1,  1'b0};
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // wishbone memory model and bus monitor
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (wb_ack) ack_count = ack_count + 1;  // transfer ends on this edge
    #1;
    check_eq(32'(wb_stb && !wb_cyc), 32'd0, "stb without cyc", bus_faults);
    if (wb_cyc) check_eq(32'(wb_adr[1:0]), 32'd0, "request alignment", bus_faults);
    if (wb_ack) begin
      wb_ack   = 1'b0;  // single beat
      mem_busy = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!mem_busy) begin
        mem_busy  = 1'b1;
        mem_adr   = wb_adr;
        wait_left = $unsigned($random(seed)) % 4;  // 0..3 wait states
      end
      check_eq(wb_adr, mem_adr, "address held until ack", bus_faults);
      if (wait_left == 0) begin
        wb_ack   = 1'b1;
        wb_dat_i = read_word(wb_adr);
      end else begin
        wait_left = wait_left - 1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("Result: FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // per trace row the head is awaited, held and resolved
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_row(input int r);
    trace_row_t  row;
    instr_t      word;
    instr_kind_e kind;
    logic        exp_taken;
    int          err_before;
    int          ack_start;
    row        = trace[r];
    err_before = errors;
    while (!issue_valid) begin
      @(posedge clk);
      #1;
    end
    word = read_word(row.pc);
    kind = kind_of(word);
    // a taken guess points away from pc+4 and a miss inverts that
    exp_taken = row.miss ? (row.next_pc == row.pc + 32'd4)
                         : (row.next_pc != row.pc + 32'd4);
    check_eq(issue.pc, row.pc, "issue pc", errors);
    check_eq(issue.instr, word, "issue instruction", errors);
    check_eq(32'(issue.kind), 32'(kind), "predecode kind", errors);
    check_eq(32'(issue.pred_taken), 32'(exp_taken), "predicted taken", errors);
    ack_start = ack_count;
    repeat (row.delay) begin
      @(posedge clk);
      #1;
    end
    resolve_valid   = 1'b1;
    resolve_next_pc = row.next_pc;
    @(negedge clk);  // verdict is combinational
    check_eq(32'(mispredict), 32'(row.miss), "mispredict", errors);
    @(posedge clk);  // completion edge pops the head
    #1;
    resolve_valid   = 1'b0;
    resolve_next_pc = '0;
    if (int'(row.delay) >= LONG_DELAY) begin
      check_eq(32'((ack_count - ack_start) <= `FE_QUEUE_DEPTH), 32'd1,
               "fetch ran past a full queue", errors);
    end
    if (kind == KIND_BRANCH) exp_branches = exp_branches + 1;
    if (kind == KIND_BRANCH && !row.miss) exp_correct = exp_correct + 1;
    if (kind == KIND_JAL || kind == KIND_JALR) exp_jumps = exp_jumps + 1;
    if (row.miss) exp_miss = exp_miss + 1;
    $display("row %0d pc %08h next %08h: %s", r, row.pc, row.next_pc,
             (errors == err_before) ? "ok" : "mismatch");
  endtask

  initial begin : main
    int err_before;
    rstn            = 1'b0;
    resolve_valid   = 1'b0;
    resolve_next_pc = '0;
    load_tables();
    repeat (10) @(posedge clk);
    #1;
    // nothing requested or issued while still in reset
    err_before = errors;
    check_eq(32'(issue_valid), 32'd0, "issue_valid in reset", errors);
    check_eq(32'(wb_stb), 32'd0, "wb_stb in reset", errors);
    check_eq(32'(mispredict), 32'd0, "mispredict in reset", errors);
    check_eq(perf.cycles, '0, "cycles in reset", errors);
    check_eq(perf.cond_branches, '0, "cond_branches in reset", errors);
    check_eq(perf.uncond_jumps, '0, "uncond_jumps in reset", errors);
    check_eq(perf.bp_correct, '0, "bp_correct in reset", errors);
    $display("reset state: %s", (errors == err_before) ? "ok" : "mismatch");
    rstn = 1'b1;

    for (int r = 0; r < N_ROWS; r++) run_row(r);

    err_before = errors;
    check_eq(perf.cond_branches, cnt_t'(exp_branches), "cond_branches", errors);
    check_eq(perf.uncond_jumps, cnt_t'(exp_jumps), "uncond_jumps", errors);
    check_eq(perf.bp_correct, cnt_t'(exp_correct), "bp_correct", errors);
    check_eq(32'(perf.cycles >= cnt_t'(N_ROWS)), 32'd1, "cycles below row count", errors);
    $display("counters: %s", (errors == err_before) ? "ok" : "mismatch");
    $display("summary: %0d rows, %0d mispredicts, %0d check errors, %0d bus faults",
             N_ROWS, exp_miss, errors, bus_faults);
    if (errors + bus_faults == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src/branch_predictor.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fe_macros.svh"

module branch_predictor (
  input  wire                     clk,
  input  wire                     rstn,
  input  wire fe_pkg::addr_t      lookup_pc,
  output logic                    hit,
  output logic                    pred_taken,
  output fe_pkg::addr_t           pred_target,
  input  wire fe_pkg::bp_update_t update
);
  import fe_pkg::*;

  localparam int ENTRIES = 1 << `FE_BTB_INDEX_W;
  localparam int TAG_W   = 32 - 2 - `FE_BTB_INDEX_W;  // pc bits above the index

  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [1:0]       ctr_t;  // 0,1 not taken   2,3 taken

  logic [ENTRIES-1:0] valid;
  tag_t               tag_mem [ENTRIES];
  addr_t              tgt_mem [ENTRIES];
  ctr_t               ctr_mem [ENTRIES];

  btb_idx_t lk_idx;
  tag_t     lk_tag;
  btb_idx_t up_idx;
  tag_t     up_tag;
  logic     up_hit;
  ctr_t     up_ctr;

  ////////////////////////////////////////////////////////////////////////////
  // lookup side
  ////////////////////////////////////////////////////////////////////////////

  assign lk_idx = lookup_pc[`FE_BTB_INDEX_W+1:2];
  assign lk_tag = lookup_pc[31:`FE_BTB_INDEX_W+2];

  assign hit         = valid[lk_idx] && (tag_mem[lk_idx] == lk_tag);
  assign pred_taken  = ctr_mem[lk_idx][1];  // msb of the 2-bit counter
  assign pred_target = tgt_mem[lk_idx];

  ////////////////////////////////////////////////////////////////////////////
  // update side
  ////////////////////////////////////////////////////////////////////////////

  assign up_idx = update.pc[`FE_BTB_INDEX_W+1:2];
  assign up_tag = update.pc[31:`FE_BTB_INDEX_W+2];
  assign up_hit = valid[up_idx] && (tag_mem[up_idx] == up_tag);

  // next counter value for the entry being written
  always_comb begin
    up_ctr = ctr_mem[up_idx];
    if (!up_hit) begin
      up_ctr = 2'd2;  // fresh entry starts weakly taken
    end else if (update.is_branch) begin
      if (update.taken && up_ctr != 2'd3) begin
        up_ctr = up_ctr + 2'd1;
      end else if (!update.taken && up_ctr != 2'd0) begin
        up_ctr = up_ctr - 2'd1;
      end
    end
  end

  // valid bits are the only control state
  always_ff @(posedge clk) begin
    if (!rstn) begin
      valid <= '0;
    end else if (update.valid && update.taken) begin
      valid[up_idx] <= 1'b1;  // allocate or keep
    end
  end

  always_ff @(posedge clk) begin
    if (update.valid && update.taken) begin
      tag_mem[up_idx] <= up_tag;
      tgt_mem[up_idx] <= update.target;  // refresh target on every taken outcome
      ctr_mem[up_idx] <= up_ctr;
    end else if (update.valid && update.is_branch && up_hit) begin
      ctr_mem[up_idx] <= up_ctr;  // not taken, count down
    end
  end

endmodule

`default_nettype wire

/* src/branch_resolver.sv */
`timescale 1ns/100ps
`default_nettype none

module branch_resolver (
  input  wire                     clk,
  input  wire                     rstn,
  input  wire fe_pkg::fetch_rec_t head,
  input  wire                     head_valid,
  input  wire                     resolve_valid,
  input  wire fe_pkg::addr_t      resolve_next_pc,
  output logic                    pop,
  output fe_pkg::redirect_t       redirect,
  output fe_pkg::bp_update_t      update,
  output fe_pkg::perf_t           perf
);
  import fe_pkg::*;

  logic  complete;
  logic  is_branch;
  logic  is_jump;
  logic  actual_taken;
  logic  pred_ok;
  addr_t seq_pc;

  ////////////////////////////////////////////////////////////////////////////
  // verdict for the head record
  ////////////////////////////////////////////////////////////////////////////

  assign complete  = head_valid && resolve_valid;
  assign pop       = complete;  // head leaves on the completion edge

  assign is_branch = (head.kind == KIND_BRANCH);
  assign is_jump   = (head.kind == KIND_JAL) || (head.kind == KIND_JALR);

  assign seq_pc       = head.pc + 32'd4;
  assign actual_taken = (resolve_next_pc != seq_pc);
  assign pred_ok      = (resolve_next_pc == head.pred_next_pc);

  // wrong guess, send fetch to the real path
  always_comb begin
    redirect.valid = complete && !pred_ok;
    redirect.pc    = resolve_next_pc;
  end

  // branches train the counter either way, jumps only when they go somewhere
  always_comb begin
    update.valid     = complete && (is_branch || (is_jump && actual_taken));
    update.is_branch = is_branch;
    update.taken     = actual_taken;
    update.pc        = head.pc;
    update.target    = resolve_next_pc;
  end

  ////////////////////////////////////////////////////////////////////////////
  // hardware counters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      perf <= '0;
    end else begin
      perf.cycles <= perf.cycles + cnt_t'(1);  // free running
      if (complete && is_branch) begin
        perf.cond_branches <= perf.cond_branches + cnt_t'(1);
      end
      if (complete && is_jump) begin
        perf.uncond_jumps <= perf.uncond_jumps + cnt_t'(1);
      end
      if (complete && is_branch && pred_ok) begin
        perf.bp_correct <= perf.bp_correct + cnt_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

/* src/fe_macros.svh */
`ifndef FE_MACROS_SVH
`define FE_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// front end sizing
////////////////////////////////////////////////////////////////////////////

`define FE_RESET_PC     32'h0000_0000  // first fetch after reset
`define FE_QUEUE_DEPTH  4              // records in flight
`define FE_BTB_INDEX_W  4              // 16 btb entries
`define FE_CNT_W        32             // perf counter width

////////////////////////////////////////////////////////////////////////////
// rv32i control flow opcodes
////////////////////////////////////////////////////////////////////////////

`define FE_OP_BRANCH    7'b1100011     // beq bne blt bge bltu bgeu
`define FE_OP_JAL       7'b1101111
`define FE_OP_JALR      7'b1100111

`endif

/* src/fe_pkg.sv */
`default_nettype none

`include "fe_macros.svh"

package fe_pkg;

  // plain vectors
  typedef logic [31:0]                 addr_t;     // byte address
  typedef logic [31:0]                 instr_t;    // raw instruction word
  typedef logic [`FE_CNT_W-1:0]        cnt_t;      // perf counter value
  typedef logic [`FE_BTB_INDEX_W-1:0]  btb_idx_t;  // pc[idx_w+1:2]

  // predecode result
  typedef enum logic [1:0] {
    KIND_OTHER,
    KIND_BRANCH,
    KIND_JAL,
    KIND_JALR
  } instr_kind_e;

  // wishbone read master
  typedef enum logic [1:0] {
    FETCH_IDLE,  // no request open
    FETCH_WAIT,  // request open, data wanted
    FETCH_DROP   // request open, data is wrong path
  } fetch_state_e;

  // one fetched instruction and its prediction
  typedef struct packed {
    addr_t       pc;
    instr_t      instr;
    instr_kind_e kind;
    logic        pred_taken;    // btb target was used
    addr_t       pred_next_pc;
  } fetch_rec_t;

  // btb write port
  typedef struct packed {
    logic  valid;
    logic  is_branch;  // conditional, moves the counter
    logic  taken;
    addr_t pc;
    addr_t target;
  } bp_update_t;

  typedef struct packed {
    logic  valid;  // one cycle pulse
    addr_t pc;
  } redirect_t;

  typedef struct packed {
    cnt_t cycles;
    cnt_t cond_branches;
    cnt_t uncond_jumps;
    cnt_t bp_correct;  // conditional only
  } perf_t;

endpackage

`default_nettype wire

/* src/fetch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fe_macros.svh"

module fetch_unit (
  input  wire                     clk,
  input  wire                     rstn,
  output logic                    wb_cyc,
  output logic                    wb_stb,
  output fe_pkg::addr_t           wb_adr,
  input  wire                     wb_ack,
  input  wire fe_pkg::instr_t     wb_dat_i,
  output logic                    push,
  output fe_pkg::fetch_rec_t      push_rec,
  input  wire                     full,
  input  wire fe_pkg::redirect_t  redirect,
  input  wire fe_pkg::bp_update_t update
);
  import fe_pkg::*;

  fetch_state_e state;
  addr_t        pc;       // next address to fetch
  addr_t        req_adr;  // address of the open request
  logic         open_req;

  logic         bp_hit;
  logic         bp_taken;
  addr_t        bp_target;

  instr_kind_e  kind;
  logic         use_btb;
  addr_t        seq_pc;
  addr_t        pred_next_pc;

  branch_predictor bp_inst (
    .clk         (clk),
    .rstn        (rstn),
    .lookup_pc   (req_adr),  // stable while the request is open
    .hit         (bp_hit),
    .pred_taken  (bp_taken),
    .pred_target (bp_target),
    .update      (update)
  );

  ////////////////////////////////////////////////////////////////////////////
  // predecode and next pc guess
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (wb_dat_i[6:0])
      `FE_OP_BRANCH: kind = KIND_BRANCH;
      `FE_OP_JAL:    kind = KIND_JAL;
      `FE_OP_JALR:   kind = KIND_JALR;
      default:       kind = KIND_OTHER;
    endcase
  end

  assign seq_pc  = req_adr + 32'd4;
  // jumps follow any hit, branches only when the counter says taken
  assign use_btb = bp_hit && ((kind == KIND_JAL) || (kind == KIND_JALR) ||
                              ((kind == KIND_BRANCH) && bp_taken));
  assign pred_next_pc = use_btb ? bp_target : seq_pc;

  ////////////////////////////////////////////////////////////////////////////
  // wishbone classic read master
  ////////////////////////////////////////////////////////////////////////////

  assign wb_cyc = (state != FETCH_IDLE);
  assign wb_stb = wb_cyc;  // single beat, stb tracks cyc
  assign wb_adr = req_adr;

  // no new request into a full queue or on a redirect edge
  assign open_req = (state == FETCH_IDLE) && !redirect.valid && !full;

  // record goes out on the ack edge unless it is being flushed
  assign push = (state == FETCH_WAIT) && wb_ack && !redirect.valid;

  always_comb begin
    push_rec.pc           = req_adr;
    push_rec.instr        = wb_dat_i;
    push_rec.kind         = kind;
    push_rec.pred_taken   = use_btb;
    push_rec.pred_next_pc = pred_next_pc;
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= FETCH_IDLE;
      pc    <= `FE_RESET_PC;
    end else begin
      case (state)
        FETCH_IDLE: begin
          if (redirect.valid) begin
            pc <= redirect.pc;
          end else if (open_req) begin
            state <= FETCH_WAIT;
          end
        end
        FETCH_WAIT: begin
          if (wb_ack) begin
            state <= FETCH_IDLE;  // cyc drops after the ack edge
            pc    <= redirect.valid ? redirect.pc : pred_next_pc;
          end else if (redirect.valid) begin
            state <= FETCH_DROP;  // bus still owes us a beat
            pc    <= redirect.pc;
          end
        end
        FETCH_DROP: begin
          if (redirect.valid) pc <= redirect.pc;
          if (wb_ack) state <= FETCH_IDLE;  // stale data thrown away
        end
        default: state <= FETCH_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (open_req) req_adr <= pc;
  end

endmodule

`default_nettype wire

/* src/inflight_queue.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fe_macros.svh"

module inflight_queue (
  input  wire                     clk,
  input  wire                     rstn,
  input  wire                     push,
  input  wire fe_pkg::fetch_rec_t push_rec,
  output logic                    full,
  input  wire                     pop,
  output fe_pkg::fetch_rec_t      head,
  output logic                    head_valid,
  input  wire                     flush
);
  import fe_pkg::*;

  localparam int DEPTH = `FE_QUEUE_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [PTR_W:0]   occ_t;  // 0 .. DEPTH

  fetch_rec_t mem [DEPTH];
  ptr_t       wr_ptr;
  ptr_t       rd_ptr;
  occ_t       count;
  logic       do_push;
  logic       do_pop;

  assign full       = (count == occ_t'(DEPTH));
  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];  // oldest record

  assign do_push = push && !full;
  assign do_pop  = pop && head_valid;

  // pointer wrap, depth need not be a power of two
  function automatic ptr_t ptr_inc(input ptr_t p);
    ptr_t nxt;
    nxt = (p == ptr_t'(DEPTH - 1)) ? '0 : p + ptr_t'(1);
    return nxt;
  endfunction

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      wr_ptr <= '0;  // drop every younger record
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop)  rd_ptr <= ptr_inc(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + occ_t'(1);
        2'b01:   count <= count - occ_t'(1);
        default: count <= count;  // both or neither
      endcase
    end
  end

  // storage, written only on an accepted push
  always_ff @(posedge clk) begin
    if (do_push && !flush) mem[wr_ptr] <= push_rec;
  end

endmodule

`default_nettype wire

/* src/rv_frontend.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_frontend (
  input  wire                 clk,
  input  wire                 rstn,
  // wishbone classic instruction port
  output logic                wb_cyc,
  output logic                wb_stb,
  output fe_pkg::addr_t       wb_adr,
  input  wire                 wb_ack,
  input  wire fe_pkg::instr_t wb_dat_i,
  // execute side
  output fe_pkg::fetch_rec_t  issue,
  output logic                issue_valid,
  input  wire                 resolve_valid,
  input  wire fe_pkg::addr_t  resolve_next_pc,
  output logic                mispredict,
  output fe_pkg::perf_t       perf
);
  import fe_pkg::*;

  logic       push;
  fetch_rec_t push_rec;
  logic       full;
  logic       pop;
  redirect_t  redirect;  // flushes queue and reloads pc
  bp_update_t update;

  fetch_unit fetch_unit_inst (
    .clk      (clk),
    .rstn     (rstn),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_adr   (wb_adr),
    .wb_ack   (wb_ack),
    .wb_dat_i (wb_dat_i),
    .push     (push),
    .push_rec (push_rec),
    .full     (full),
    .redirect (redirect),
    .update   (update)
  );

  inflight_queue inflight_queue_inst (
    .clk        (clk),
    .rstn       (rstn),
    .push       (push),
    .push_rec   (push_rec),
    .full       (full),
    .pop        (pop),
    .head       (issue),
    .head_valid (issue_valid),
    .flush      (redirect.valid)
  );

  branch_resolver branch_resolver_inst (
    .clk             (clk),
    .rstn            (rstn),
    .head            (issue),
    .head_valid      (issue_valid),
    .resolve_valid   (resolve_valid),
    .resolve_next_pc (resolve_next_pc),
    .pop             (pop),
    .redirect        (redirect),
    .update          (update),
    .perf            (perf)
  );

  assign mispredict = redirect.valid;

endmodule

`default_nettype wire
